// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_global_prediction
RTL_TOP   ?= global_prediction_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_global_prediction.sv
module tb_global_prediction;
    import bp_pkg::*;

    localparam int HB         = 4;
    localparam int BIB        = 4;
    localparam int WAIT_LIMIT = 64;

    logic clk;
    logic reset;
    logic resolve_valid, resolve_branch, resolve_jump;
    logic resolve_taken, resolve_pred_taken;
    logic mret, exception;
    pc_t  resolve_pc, resolve_target, epc, trap_vector;
    pc_t  pc;
    logic predict_taken, btb_hit, mispredict;

    // Reference model state
    logic [HB-1:0] m_hist;
    counter_t      m_ctr [1 << HB];
    logic          m_valid [1 << BIB];
    pc_t           m_btb_pc [1 << BIB];
    pc_t           m_target [1 << BIB];
    pc_t           m_pc;
    pc_t           m_next;
    logic          m_hit, m_pred, m_misp;

    int  errors;
    int  timeouts;
    // Three branches at BTB indices 4, 9 and 14
    pc_t bpc [3] = '{32'h0000_0010, 32'h0000_0024, 32'h0000_0038};
    pc_t btgt [3] = '{32'h0000_0030, 32'h0000_0008, 32'h0000_0004};

    global_prediction_top #(
        .HISTORY_BITS(HB),
        .BTB_INDEX_BITS(BIB)
    ) uut (
        .clk(clk), .reset(reset),
        .resolve_valid(resolve_valid), .resolve_branch(resolve_branch),
        .resolve_jump(resolve_jump), .resolve_pc(resolve_pc),
        .resolve_target(resolve_target), .resolve_taken(resolve_taken),
        .resolve_pred_taken(resolve_pred_taken), .epc(epc),
        .trap_vector(trap_vector), .mret(mret), .exception(exception),
        .pc(pc), .predict_taken(predict_taken), .btb_hit(btb_hit),
        .mispredict(mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Saturating counter step in table form
    function automatic counter_t step_counter(counter_t c, logic t);
        case (c)
            STRONG_NT: return t ? WEAK_NT : STRONG_NT;
            WEAK_NT:   return t ? WEAK_T : STRONG_NT;
            WEAK_T:    return t ? STRONG_T : WEAK_NT;
            default:   return t ? STRONG_T : WEAK_T;
        endcase
    endfunction

    // Model lookup and next-PC priority
    always_comb begin : model_lookup
        logic [BIB-1:0] bi;
        bi     = m_pc[BIB+1:2];
        m_hit  = m_valid[bi] && (m_btb_pc[bi][31:BIB+2] == m_pc[31:BIB+2]);
        m_pred = m_hit && m_ctr[m_hist ^ m_pc[HB+1:2]][1];
        m_misp = resolve_valid && resolve_branch && (resolve_taken != resolve_pred_taken);
        m_next = exception ? trap_vector
               : mret ? epc
               : (resolve_valid && resolve_jump) ? resolve_target
               : m_misp ? (resolve_taken ? resolve_target : resolve_pc + INSTR_BYTES)
               : m_pred ? m_target[bi]
               : m_pc + INSTR_BYTES;
    end

    // Model training at the end of the report cycle
    always @(posedge clk) begin
        if (reset) begin
            m_pc   <= RESET_PC;
            m_hist <= '0;
            for (int i = 0; i < (1 << HB); i++) begin
                m_ctr[i] <= WEAK_NT;
            end
            for (int i = 0; i < (1 << BIB); i++) begin
                m_valid[i] <= 1'b0;
            end
        end else begin
            m_pc <= m_next;
            if (resolve_valid && resolve_branch) begin
                m_ctr[m_hist ^ resolve_pc[HB+1:2]] <=
                    step_counter(m_ctr[m_hist ^ resolve_pc[HB+1:2]], resolve_taken);
                m_hist <= {m_hist[HB-2:0], resolve_taken};
            end
            if (resolve_valid && (resolve_jump || (resolve_branch && resolve_taken))) begin
                m_valid[resolve_pc[BIB+1:2]]  <= 1'b1;
                m_btb_pc[resolve_pc[BIB+1:2]] <= resolve_pc;
                m_target[resolve_pc[BIB+1:2]] <= resolve_target;
            end
        end
    end

    task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("FAIL t=%0t %s got %h expected %h", $time, what, got, exp);
    endtask

    // Per-cycle comparison against the model
    a_pc : assert property (@(posedge clk) disable iff (reset) pc == m_pc)
        else report_mismatch("pc", $sampled(pc), $sampled(m_pc));
    a_pred : assert property (@(posedge clk) disable iff (reset) predict_taken == m_pred)
        else report_mismatch("predict_taken", 32'($sampled(predict_taken)), 32'($sampled(m_pred)));
    a_hit : assert property (@(posedge clk) disable iff (reset) btb_hit == m_hit)
        else report_mismatch("btb_hit", 32'($sampled(btb_hit)), 32'($sampled(m_hit)));
    a_misp : assert property (@(posedge clk) disable iff (reset) mispredict == m_misp)
        else report_mismatch("mispredict", 32'($sampled(mispredict)), 32'($sampled(m_misp)));

    // One-cycle execute report
    task automatic drive_report(logic br, logic jmp, pc_t rpc, pc_t tgt, logic tk, logic ptk);
        @(posedge clk);
        resolve_valid      <= 1'b1;
        resolve_branch     <= br;
        resolve_jump       <= jmp;
        resolve_pc         <= rpc;
        resolve_target     <= tgt;
        resolve_taken      <= tk;
        resolve_pred_taken <= ptk;
    endtask

    task automatic release_inputs();
        @(posedge clk);
        resolve_valid  <= 1'b0;
        resolve_branch <= 1'b0;
        resolve_jump   <= 1'b0;
        mret           <= 1'b0;
        exception      <= 1'b0;
    endtask

    // Trap fetch onto a chosen address for one cycle
    task automatic steer_fetch(pc_t addr);
        @(posedge clk);
        exception   <= 1'b1;
        trap_vector <= addr;
        release_inputs();
    endtask

    task automatic wait_for_pc(pc_t addr);
        for (int n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (pc == addr) return;
        end
        timeouts++;
        $display("Timed out at t=%0t waiting for fetch to reach %h", $time, addr);
    endtask

    initial begin
        int   j;
        logic tk;
        logic ptk;
        errors = 0;
        timeouts = 0;
        reset = 1'b1;
        resolve_valid = 1'b0;
        resolve_branch = 1'b0;
        resolve_jump = 1'b0;
        resolve_taken = 1'b0;
        resolve_pred_taken = 1'b0;
        resolve_pc = '0;
        resolve_target = '0;
        mret = 1'b0;
        exception = 1'b0;
        epc = '0;
        trap_vector = '0;
        void'($urandom(32'h2961_970c));
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (pc == RESET_PC) else report_mismatch("reset pc", pc, RESET_PC);
        assert (!predict_taken && !btb_hit && !mispredict)
            else report_mismatch("reset flags", 32'({predict_taken, btb_hit, mispredict}), 32'd0);
        repeat (4) @(posedge clk);

        // Taken branch predicted not taken, fills the BTB
        drive_report(1'b1, 1'b0, bpc[0], btgt[0], 1'b1, 1'b0);
        @(negedge clk);
        assert (mispredict) else report_mismatch("mispredict", 32'(mispredict), 32'd1);
        release_inputs();
        @(negedge clk);
        assert (pc == btgt[0]) else report_mismatch("recovery pc", pc, btgt[0]);
        // Not taken branch predicted taken, falls through
        drive_report(1'b1, 1'b0, bpc[1], btgt[1], 1'b0, 1'b1);
        release_inputs();
        @(negedge clk);
        assert (pc == bpc[1] + INSTR_BYTES)
            else report_mismatch("fall-through pc", pc, bpc[1] + INSTR_BYTES);
        // Fetch reaches the filled branch
        steer_fetch(bpc[0] - 8);
        wait_for_pc(bpc[0]);
        assert (btb_hit) else report_mismatch("btb_hit", 32'(btb_hit), 32'd1);

        // Jump redirects without a mispredict
        drive_report(1'b0, 1'b1, 32'h0000_0040, 32'h0000_0100, 1'b1, 1'b0);
        @(negedge clk);
        assert (!mispredict) else report_mismatch("mispredict", 32'(mispredict), 32'd0);
        release_inputs();
        @(negedge clk);
        assert (pc == 32'h0000_0100) else report_mismatch("jump pc", pc, 32'h0000_0100);

        // mret wins over a jump, exception over a mispredict
        drive_report(1'b0, 1'b1, 32'h0000_0040, 32'h0000_0100, 1'b1, 1'b0);
        mret <= 1'b1;
        epc  <= 32'h0000_0200;
        release_inputs();
        @(negedge clk);
        assert (pc == 32'h0000_0200) else report_mismatch("mret pc", pc, 32'h0000_0200);
        drive_report(1'b1, 1'b0, bpc[2], btgt[2], 1'b1, 1'b0);
        exception   <= 1'b1;
        trap_vector <= 32'h0000_0300;
        release_inputs();
        @(negedge clk);
        assert (pc == 32'h0000_0300) else report_mismatch("trap pc", pc, 32'h0000_0300);

        // Random outcomes with the prediction read from the model table
        for (int i = 0; i < 200; i++) begin
            j = $urandom % 3;
            if (i % 4 == 0) begin
                steer_fetch(bpc[j] - 8);
                wait_for_pc(bpc[j]);
            end
            repeat ($urandom % 3) @(posedge clk);
            @(negedge clk);
            tk  = ($urandom % 2) != 0;
            ptk = m_ctr[m_hist ^ bpc[j][HB+1:2]][1];
            drive_report(1'b1, 1'b0, bpc[j], btgt[j], tk, ptk);
            release_inputs();
        end

        repeat (4) @(posedge clk);
        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/bp_if.sv
// Resolved branch or jump from the execute stage, one strobe per report
interface resolve_if;
    import bp_pkg::*;

    logic valid;
    logic is_branch;
    logic is_jump;
    pc_t  pc;
    pc_t  target;
    logic taken;
    // Direction predicted back at fetch time
    logic pred_taken;

    // Execute side
    modport source (
        output valid, is_branch, is_jump, pc, target, taken, pred_taken
    );

    // Predictor and recovery side
    modport update (
        input valid, is_branch, is_jump, pc, target, taken, pred_taken
    );
endinterface

// Lookup for the current fetch PC
interface fetch_if;
    import bp_pkg::*;

    pc_t  pc;
    logic hit;
    pc_t  target;
    logic taken;

    modport control (output pc, input hit, target, taken);
    // Pattern table reads pc, answers with the direction
    modport pht (input pc, output taken);
    // BTB reads pc, answers with hit and target
    modport btb (input pc, output hit, target);
endinterface

// File: hdl/bp_pkg.sv
package bp_pkg;

    // Address width shared by fetch and execute
    localparam int PC_WIDTH = 32;

    // One instruction address
    typedef logic [PC_WIDTH-1:0] pc_t;

    // First fetch address out of reset
    localparam pc_t RESET_PC = 32'h0000_0000;

    // Sequential fetch step
    localparam pc_t INSTR_BYTES = 32'd4;

    // Two-bit saturating counter, upper bit is the predicted direction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_t;

endpackage

// File: hdl/branch_recovery_unit.sv
module branch_recovery_unit (
    resolve_if.update    upd,
    output logic         mispredict,
    output logic         redirect,
    output bp_pkg::pc_t  redirect_pc
);
    import bp_pkg::*;

    logic branch_report;
    logic jump_report;
    pc_t  fall_through;

    // Report type qualified by the strobe
    assign branch_report = upd.valid && upd.is_branch;
    assign jump_report   = upd.valid && upd.is_jump;

    // Next sequential address after the resolved instruction
    assign fall_through = upd.pc + INSTR_BYTES;

    // Direction mismatch only; target aliasing is not tracked
    assign mispredict = branch_report && (upd.taken != upd.pred_taken);

    // Jumps always steer fetch
    assign redirect = mispredict || jump_report;

    // Jump or taken branch goes to target, else fall through
    always_comb begin
        if (upd.is_jump || upd.taken) begin
            redirect_pc = upd.target;
        end else begin
            redirect_pc = fall_through;
        end
    end

endmodule

// File: hdl/branch_target_buffer.sv
module branch_target_buffer #(
    parameter int BTB_INDEX_BITS = 4
) (
    input logic          clk,
    input logic          reset,
    resolve_if.update    upd,
    fetch_if.btb         fetch
);
    import bp_pkg::*;

    localparam int DEPTH    = 1 << BTB_INDEX_BITS;
    // Tag is everything above the index and the byte offset
    localparam int TAG_LSB  = BTB_INDEX_BITS + 2;
    localparam int TAG_BITS = PC_WIDTH - TAG_LSB;

    logic                valid_q  [DEPTH];
    logic [TAG_BITS-1:0] tag_q    [DEPTH];
    pc_t                 target_q [DEPTH];

    logic [BTB_INDEX_BITS-1:0] lookup_idx;
    logic [TAG_BITS-1:0]       lookup_tag;
    logic [BTB_INDEX_BITS-1:0] fill_idx;
    logic [TAG_BITS-1:0]       fill_tag;
    logic                      fill;

    // Fetch side split
    assign lookup_idx = fetch.pc[TAG_LSB-1:2];
    assign lookup_tag = fetch.pc[PC_WIDTH-1:TAG_LSB];

    // Resolve side split
    assign fill_idx = upd.pc[TAG_LSB-1:2];
    assign fill_tag = upd.pc[PC_WIDTH-1:TAG_LSB];

    // Taken branches and every jump allocate
    assign fill = upd.valid && ((upd.is_branch && upd.taken) || upd.is_jump);

    assign fetch.hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign fetch.target = target_q[lookup_idx];

    // Valid bits only
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    // Tag and target payload
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[fill_idx]    <= fill_tag;
            target_q[fill_idx] <= upd.target;
        end
    end

    // A hit must point at a word-aligned instruction
    a_target_aligned : assert property (
        @(posedge clk) disable iff (reset)
        fetch.hit |-> (fetch.target[1:0] == 2'b00)
    );

endmodule

// File: hdl/global_prediction_top.sv
module global_prediction_top #(
    parameter int HISTORY_BITS   = 4,
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         resolve_valid,
    input  logic         resolve_branch,
    input  logic         resolve_jump,
    input  bp_pkg::pc_t  resolve_pc,
    input  bp_pkg::pc_t  resolve_target,
    input  logic         resolve_taken,
    input  logic         resolve_pred_taken,
    input  bp_pkg::pc_t  epc,
    input  bp_pkg::pc_t  trap_vector,
    input  logic         mret,
    input  logic         exception,
    output bp_pkg::pc_t  pc,
    output logic         predict_taken,
    output logic         btb_hit,
    output logic         mispredict
);
    import bp_pkg::*;

    resolve_if rsv ();
    fetch_if   fch ();

    logic redirect;
    pc_t  redirect_pc;

    // Execute report onto the shared bundle
    assign rsv.valid      = resolve_valid;
    assign rsv.is_branch  = resolve_branch;
    assign rsv.is_jump    = resolve_jump;
    assign rsv.pc         = resolve_pc;
    assign rsv.target     = resolve_target;
    assign rsv.taken      = resolve_taken;
    assign rsv.pred_taken = resolve_pred_taken;

    // Raw BTB hit for visibility
    assign btb_hit = fch.hit;

    pattern_history_table #(
        .HISTORY_BITS(HISTORY_BITS)
    ) u_pht (
        .clk   (clk),
        .reset (reset),
        .upd   (rsv.update),
        .fetch (fch.pht)
    );

    branch_target_buffer #(
        .BTB_INDEX_BITS(BTB_INDEX_BITS)
    ) u_btb (
        .clk   (clk),
        .reset (reset),
        .upd   (rsv.update),
        .fetch (fch.btb)
    );

    branch_recovery_unit u_recovery (
        .upd         (rsv.update),
        .mispredict  (mispredict),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    next_pc_control u_npc (
        .clk           (clk),
        .reset         (reset),
        .fetch         (fch.control),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .mret          (mret),
        .exception     (exception),
        .epc           (epc),
        .trap_vector   (trap_vector),
        .pc            (pc),
        .predict_taken (predict_taken)
    );

endmodule

// File: hdl/next_pc_control.sv
module next_pc_control (
    input  logic         clk,
    input  logic         reset,
    fetch_if.control     fetch,
    input  logic         redirect,
    input  bp_pkg::pc_t  redirect_pc,
    input  logic         mret,
    input  logic         exception,
    input  bp_pkg::pc_t  epc,
    input  bp_pkg::pc_t  trap_vector,
    output bp_pkg::pc_t  pc,
    output logic         predict_taken
);
    import bp_pkg::*;

    pc_t pc_q;
    pc_t pc_next;
    pc_t seq_pc;
    pc_t predicted_pc;

    // Taken only when the BTB also knows where to go
    assign predict_taken = fetch.taken && fetch.hit;

    assign seq_pc = pc_q + INSTR_BYTES;

    // Speculative choice for this fetch
    assign predicted_pc = predict_taken ? fetch.target : seq_pc;

    // Trap beats mret, mret beats execute, execute beats prediction
    always_comb begin
        if (exception) begin
            pc_next = trap_vector;
        end else if (mret) begin
            pc_next = epc;
        end else if (redirect) begin
            pc_next = redirect_pc;
        end else begin
            pc_next = predicted_pc;
        end
    end

    // Fetch advances every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign fetch.pc = pc_q;
    assign pc       = pc_q;

    // Privileged unit never signals trap and return together
    a_mret_exception_excl : assert property (
        @(posedge clk) disable iff (reset)
        !(mret && exception)
    );

endmodule

// File: hdl/pattern_history_table.sv
module pattern_history_table #(
    parameter int HISTORY_BITS = 4
) (
    input logic          clk,
    input logic          reset,
    resolve_if.update    upd,
    fetch_if.pht         fetch
);
    import bp_pkg::*;

    localparam int DEPTH = 1 << HISTORY_BITS;

    // Global history, newest outcome in bit 0
    logic [HISTORY_BITS-1:0] history_q;
    counter_t                ctr_q [DEPTH];

    logic [HISTORY_BITS-1:0] lookup_idx;
    logic [HISTORY_BITS-1:0] train_idx;
    logic                    train;

    // Move one step toward the outcome, stop at the ends
    function automatic counter_t saturate(input counter_t cur, input logic taken);
        counter_t nxt;
        nxt = cur;
        if (taken && cur != STRONG_T) begin
            nxt = counter_t'(cur + 2'd1);
        end else if (!taken && cur != STRONG_NT) begin
            nxt = counter_t'(cur - 2'd1);
        end
        return nxt;
    endfunction

    // gshare index, history XOR word address bits
    assign lookup_idx = history_q ^ fetch.pc[HISTORY_BITS+1:2];
    assign train_idx  = history_q ^ upd.pc[HISTORY_BITS+1:2];

    // Only conditional branches train the table
    assign train = upd.valid && upd.is_branch;

    // Direction comes straight from the counter MSB
    assign fetch.taken = ctr_q[lookup_idx][1];

    always_ff @(posedge clk) begin
        if (reset) begin
            history_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                ctr_q[i] <= WEAK_NT;
            end
        end else if (train) begin
            ctr_q[train_idx] <= saturate(ctr_q[train_idx], upd.taken);
            // Shift in the resolved direction
            history_q <= {history_q[HISTORY_BITS-2:0], upd.taken};
        end
    end

    // Execute never reports a branch and a jump at once
    a_branch_xor_jump : assert property (
        @(posedge clk) disable iff (reset)
        upd.valid |-> !(upd.is_branch && upd.is_jump)
    );

endmodule

// File: verilog.f
hdl/bp_pkg.sv
hdl/bp_if.sv
hdl/pattern_history_table.sv
hdl/branch_target_buffer.sv
hdl/branch_recovery_unit.sv
hdl/next_pc_control.sv
hdl/global_prediction_top.sv
bench/tb_global_prediction.sv
